/* verilog/hist_pkg.sv */
package hist_pkg;

    // time bins per pixel histogram
    localparam int BIN_NUM = 8;
    // hit code selects one bin
    localparam int CODE_W = $clog2(BIN_NUM);

    // pixels per acquisition
    localparam int PIXEL_NUM = 2;
    localparam int PIX_W = $clog2(PIXEL_NUM);

    // hits per pixel per acquisition
    localparam int DATA_NUM = 2;
    localparam int HIT_W = $clog2(DATA_NUM);

    // acquisitions per histogram frame
    localparam int ACQ_NUM = 10;
    localparam int ACQ_W = $clog2(ACQ_NUM);

    // one bin count, saturates at all ones
    localparam int CNT_W = 4;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // one bank holds every bin of every pixel
    localparam int ENTRY_NUM = PIXEL_NUM * BIN_NUM;
    // entry address is {pixel, bin}
    localparam int ENTRY_W = PIX_W + CODE_W;

    // fill bank and readout bank
    localparam int BANK_NUM = 2;

    // last values of the nested counters, sized to their registers
    localparam logic [HIT_W-1:0] HIT_LAST = HIT_W'(DATA_NUM - 1);
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(ACQ_NUM - 1);

    // address of the final entry in a readout scan
    localparam logic [ENTRY_W-1:0] ENTRY_LAST = ENTRY_W'(ENTRY_NUM - 1);

    // readout sequencer states
    typedef enum logic [0:0] {
        RD_IDLE,
        RD_SCAN
    } readout_state_t;

endpackage

/* verilog/hist_frame_counter.sv */
`timescale 1ns/1ps

module hist_frame_counter (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      hit,
    output logic [hist_pkg::PIX_W-1:0] pixel,
    output logic                      bank,
    output logic                      frame_done
);

    // hits taken so far for the current pixel
    logic [hist_pkg::HIT_W-1:0] hit_cnt;
    // acquisitions finished in this frame
    logic [hist_pkg::ACQ_W-1:0] acq_cnt;

    // wrap conditions of each level
    logic last_hit;
    logic last_pix;
    logic last_acq;

    assign last_hit = (hit_cnt == hist_pkg::HIT_LAST);
    assign last_pix = (pixel == hist_pkg::PIX_LAST);
    assign last_acq = (acq_cnt == hist_pkg::ACQ_LAST);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt    <= '0;
            pixel      <= '0;
            acq_cnt    <= '0;
            bank       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // single cycle pulse by default
            frame_done <= 1'b0;
            if (hit) begin
                if (!last_hit) begin
                    hit_cnt <= hit_cnt + 1'b1;
                end else begin
                    // pixel complete
                    hit_cnt <= '0;
                    if (!last_pix) begin
                        pixel <= pixel + 1'b1;
                    end else begin
                        // acquisition complete, back to pixel 0
                        pixel <= '0;
                        if (!last_acq) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            // last hit of the frame
                            acq_cnt    <= '0;
                            frame_done <= 1'b1;
                            // new hits go to the other bank
                            bank       <= ~bank;
                        end
                    end
                end
            end
        end
    end

    // frame end is a one cycle pulse, two frames need many more hits
    a_frame_done_pulse: assert property (
        @(posedge clk) disable iff (!res)
        frame_done |=> !frame_done
    );

endmodule

/* verilog/hist_bin_ram.sv */
`timescale 1ns/1ps

module hist_bin_ram (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        hit,
    input  logic [hist_pkg::CODE_W-1:0]  hit_code,
    input  logic [hist_pkg::PIX_W-1:0]   pixel,
    input  logic                        bank,
    input  logic                        rd_en,
    input  logic [hist_pkg::ENTRY_W-1:0] rd_addr,
    output logic [hist_pkg::CNT_W-1:0]   rd_data
);

    // two banks of bin counts
    logic [hist_pkg::CNT_W-1:0] mem [hist_pkg::BANK_NUM][hist_pkg::ENTRY_NUM];

    // increment side
    logic [hist_pkg::ENTRY_W-1:0] wr_addr;
    logic [hist_pkg::CNT_W-1:0]   hit_cur;
    logic [hist_pkg::CNT_W-1:0]   hit_next;

    // readout always uses the bank not being filled
    logic rd_bank;

    // pixel is the high part of the address, bin the low part
    assign wr_addr = {pixel, hit_code};

    // current count of the addressed bin
    assign hit_cur = mem[bank][wr_addr];

    // saturating increment
    assign hit_next = (hit_cur == hist_pkg::CNT_MAX) ? hit_cur : hit_cur + 1'b1;

    assign rd_bank = ~bank;

    // combinational read of the finished bank
    assign rd_data = mem[rd_bank][rd_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // full wipe of both banks
            for (int b = 0; b < hist_pkg::BANK_NUM; b++) begin
                for (int e = 0; e < hist_pkg::ENTRY_NUM; e++) begin
                    mem[b][e] <= '0;
                end
            end
        end else begin
            // read-modify-write in the fill bank
            if (hit) begin
                mem[bank][wr_addr] <= hit_next;
            end
            // clear on read in the other bank
            if (rd_en) begin
                mem[rd_bank][rd_addr] <= '0;
            end
        end
    end

    // Bank must not flip while a readout burst runs. Otherwise the
    // read would move onto the bank that is taking hits.
    a_bank_stable_during_read: assert property (
        @(posedge clk) disable iff (!res)
        (rd_en && $past(rd_en)) |-> $stable(bank)
    );

endmodule

/* verilog/hist_readout.sv */
`timescale 1ns/1ps

module hist_readout (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        frame_done,
    output logic                        rd_en,
    output logic [hist_pkg::ENTRY_W-1:0] rd_addr,
    input  logic [hist_pkg::CNT_W-1:0]   rd_data,
    output logic                        out_valid,
    output logic [hist_pkg::PIX_W-1:0]   out_pixel,
    output logic [hist_pkg::CODE_W-1:0]  out_bin,
    output logic [hist_pkg::CNT_W-1:0]   bin_count
);

    hist_pkg::readout_state_t state;

    // entry 0 is read in the frame_done cycle itself,
    // the rest while scanning
    assign rd_en = frame_done || (state == hist_pkg::RD_SCAN);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= hist_pkg::RD_IDLE;
            rd_addr   <= '0;
            out_valid <= 1'b0;
        end else begin
            // one output word per read
            out_valid <= rd_en;
            case (state)
                hist_pkg::RD_IDLE: begin
                    if (frame_done) begin
                        // entry 0 taken, continue at 1
                        state   <= hist_pkg::RD_SCAN;
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                hist_pkg::RD_SCAN: begin
                    if (rd_addr == hist_pkg::ENTRY_LAST) begin
                        // bank fully streamed
                        state   <= hist_pkg::RD_IDLE;
                        rd_addr <= '0;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                default: begin
                    state   <= hist_pkg::RD_IDLE;
                    rd_addr <= '0;
                end
            endcase
        end
    end

    // output word, follows the read by one cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_pixel <= rd_addr[hist_pkg::ENTRY_W-1 -: hist_pkg::PIX_W];
            out_bin   <= rd_addr[hist_pkg::CODE_W-1:0];
            bin_count <= rd_data;
        end
    end

    // a frame must take longer than one scan, no overrun handling
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!res)
        (state == hist_pkg::RD_SCAN) |-> !frame_done
    );

endmodule

/* verilog/hist_builder_top.sv */
`timescale 1ns/1ps

module hist_builder_top (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       hit,
    input  logic [hist_pkg::CODE_W-1:0] hit_code,
    output logic                       out_valid,
    output logic [hist_pkg::PIX_W-1:0]  out_pixel,
    output logic [hist_pkg::CODE_W-1:0] out_bin,
    output logic [hist_pkg::CNT_W-1:0]  bin_count,
    output logic                       bank,
    output logic                       frame_done
);

    // pixel of the hit in flight
    logic [hist_pkg::PIX_W-1:0]   pixel;
    // read-and-clear port
    logic                        rd_en;
    logic [hist_pkg::ENTRY_W-1:0] rd_addr;
    logic [hist_pkg::CNT_W-1:0]   rd_data;

    hist_frame_counter hist_frame_counter_inst (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .pixel      (pixel),
        .bank       (bank),
        .frame_done (frame_done)
    );

    hist_bin_ram hist_bin_ram_inst (
        .clk      (clk),
        .res      (res),
        .hit      (hit),
        .hit_code (hit_code),
        .pixel    (pixel),
        .bank     (bank),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    hist_readout hist_readout_inst (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .bin_count  (bin_count)
    );

endmodule

/* dv/hist_builder_tb.sv */
`timescale 1ns/1ps

module hist_builder_tb;

    // rows for seven single frames, a frame pair and a partial frame
    localparam int ROW_NUM = 384;
    localparam int FRAME_HITS = hist_pkg::PIXEL_NUM * hist_pkg::DATA_NUM * hist_pkg::ACQ_NUM;
    // highest bin count before saturation
    localparam int CNT_TOP = (1 << hist_pkg::CNT_W) - 1;
    // readout tail per frame and spare cycles
    localparam int FRAME_TAIL = 20;
    localparam int MARGIN = 200;

    // one table row is one hit
    typedef struct packed {
        logic [7:0]                  test;
        logic [hist_pkg::CODE_W-1:0] code;
        logic [1:0]                  gap;
        logic                        rst;
    } row_t;

    logic                        clk;
    logic                        res;
    logic                        hit;
    logic [hist_pkg::CODE_W-1:0] hit_code;
    logic                        out_valid;
    logic [hist_pkg::PIX_W-1:0]  out_pixel;
    logic [hist_pkg::CODE_W-1:0] out_bin;
    logic [hist_pkg::CNT_W-1:0]  bin_count;
    logic                        bank;
    logic                        frame_done;

    row_t        rows [ROW_NUM];
    int          n_rows;
    logic [31:0] lfsr;

    // run bookkeeping
    int cycles;
    int cycle_limit;
    int checks;
    int errors;
    int tests;
    int test_checks;
    int test_errors;

    // reference model with two banks and the nested counters
    int  m_mem [2][hist_pkg::ENTRY_NUM];
    int  m_bank;
    int  m_hit;
    int  m_pix;
    int  m_acq;
    // frame_done due this cycle
    bit  fd_exp;
    // words still due in the running burst
    int  valid_left;
    int  exp_addr_q [$];
    int  exp_cnt_q [$];

    hist_builder_top hist_builder_top_inst (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .hit_code   (hit_code),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .bin_count  (bin_count),
        .bank       (bank),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    task automatic add_row(input int test, input int code, input int gap, input bit rst);
        rows[n_rows].test = test[7:0];
        rows[n_rows].code = code[hist_pkg::CODE_W-1:0];
        rows[n_rows].gap  = gap[1:0];
        rows[n_rows].rst  = rst;
        n_rows++;
    endtask

    task automatic build_table();
        int code;
        int gap;
        // test 1 has random codes back to back
        for (int i = 0; i < FRAME_HITS; i++) begin
            add_row(1, rand_bits(hist_pkg::CODE_W), 0, 1'b0);
        end
        // test 2 puts all 20 pixel 0 hits on bin 5
        for (int i = 0; i < FRAME_HITS; i++) begin
            if ((i / hist_pkg::DATA_NUM) % hist_pkg::PIXEL_NUM == 0) begin
                code = 5;
            end else begin
                code = rand_bits(hist_pkg::CODE_W);
            end
            add_row(2, code, 0, 1'b0);
        end
        // test 3 runs two frames back to back so the second fills during the first readout
        for (int i = 0; i < 2 * FRAME_HITS; i++) begin
            code = (i < FRAME_HITS) ? i % hist_pkg::BIN_NUM : rand_bits(hist_pkg::CODE_W);
            add_row(3, code, 0, 1'b0);
        end
        // test 4 is a plain frame for the burst timing
        for (int i = 0; i < FRAME_HITS; i++) begin
            add_row(4, rand_bits(hist_pkg::CODE_W), 0, 1'b0);
        end
        // test 5 adds random idle gaps
        for (int i = 0; i < FRAME_HITS; i++) begin
            code = rand_bits(hist_pkg::CODE_W);
            gap = rand_bits(2);
            add_row(5, code, gap, 1'b0);
        end
        // test 6 leaves partial hits in bank 1, resets, then runs two full frames
        // the second of them fills bank 1 again and sees any stale counts
        for (int i = 0; i < 3 * FRAME_HITS + 24; i++) begin
            add_row(6, rand_bits(hist_pkg::CODE_W), 0, i == FRAME_HITS + 24);
        end
    endtask

    task automatic check_value(input string name, input int exp, input int got);
        checks++;
        if (exp != got) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    function automatic void reset_model();
        for (int b = 0; b < 2; b++) begin
            for (int e = 0; e < hist_pkg::ENTRY_NUM; e++) begin
                m_mem[b][e] = 0;
            end
        end
        m_bank = 0;
        m_hit = 0;
        m_pix = 0;
        m_acq = 0;
        fd_exp = 1'b0;
        valid_left = 0;
        exp_addr_q.delete();
        exp_cnt_q.delete();
    endfunction

    // snapshot the finished bank as the stream, then clear it
    function automatic void close_frame();
        for (int e = 0; e < hist_pkg::ENTRY_NUM; e++) begin
            exp_addr_q.push_back(e);
            exp_cnt_q.push_back(m_mem[m_bank][e]);
            m_mem[m_bank][e] = 0;
        end
        m_bank = 1 - m_bank;
        fd_exp = 1'b1;
    endfunction

    function automatic void apply_hit(input int code);
        int addr;
        // pixel high, bin low
        addr = m_pix * hist_pkg::BIN_NUM + code;
        if (m_mem[m_bank][addr] < CNT_TOP) begin
            m_mem[m_bank][addr]++;
        end
        m_hit++;
        if (m_hit == hist_pkg::DATA_NUM) begin
            m_hit = 0;
            m_pix++;
            if (m_pix == hist_pkg::PIXEL_NUM) begin
                m_pix = 0;
                m_acq++;
                if (m_acq == hist_pkg::ACQ_NUM) begin
                    m_acq = 0;
                    close_frame();
                end
            end
        end
    endfunction

    // sample mid cycle where inputs and outputs have settled
    always @(negedge clk) begin : monitor
        if (!res) begin
            if (exp_addr_q.size() != 0) begin
                errors++;
                $display("%0t ns: %0d readout words lost to a reset", $time, exp_addr_q.size());
            end
            reset_model();
            check_value("bank", 0, bank);
            check_value("out_valid", 0, out_valid);
            check_value("frame_done", 0, frame_done);
        end else begin
            check_value("frame_done", fd_exp, frame_done);
            check_value("bank", m_bank, bank);
            if (valid_left > 0) begin
                if (out_valid) begin
                    check_value("out_pixel", exp_addr_q[0] / hist_pkg::BIN_NUM, out_pixel);
                    check_value("out_bin", exp_addr_q[0] % hist_pkg::BIN_NUM, out_bin);
                    check_value("bin_count", exp_cnt_q[0], bin_count);
                end else begin
                    errors++;
                    $display("%0t ns: readout word for pixel %0d bin %0d did not arrive",
                             $time, exp_addr_q[0] / hist_pkg::BIN_NUM,
                             exp_addr_q[0] % hist_pkg::BIN_NUM);
                end
                void'(exp_addr_q.pop_front());
                void'(exp_cnt_q.pop_front());
                valid_left--;
            end else if (out_valid) begin
                errors++;
                $display("%0t ns: out_valid high outside a readout burst", $time);
            end
            // burst starts the cycle after frame_done
            if (fd_exp) begin
                valid_left = hist_pkg::ENTRY_NUM;
            end
            fd_exp = 1'b0;
            if (hit) begin
                apply_hit(int'(hit_code));
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        hit <= 1'b0;
        res <= 1'b0;
        repeat (2) @(posedge clk);
        res <= 1'b1;
    endtask

    // idle until the last burst of the test has streamed
    task automatic finish_test(input int test);
        @(posedge clk);
        hit <= 1'b0;
        while (exp_addr_q.size() != 0 || valid_left != 0 || fd_exp) begin
            @(posedge clk);
        end
        @(posedge clk);
        tests++;
        $display("test %0d done: %0d checks, %0d errors", test,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        res = 1'b0;
        hit = 1'b0;
        hit_code = '0;
        lfsr = 32'hd73f;
        n_rows = 0;
        cycles = 0;
        checks = 0;
        errors = 0;
        tests = 0;
        test_checks = 0;
        test_errors = 0;
        build_table();
        // gaps and hits, reset cycles, readout tails, margin
        cycle_limit = MARGIN + 3 + FRAME_TAIL * (n_rows / FRAME_HITS + 1);
        for (int r = 0; r < n_rows; r++) begin
            cycle_limit += rows[r].gap + 1 + (rows[r].rst ? 3 : 0);
        end
        repeat (2) @(posedge clk);
        res <= 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            if (rows[r].rst) begin
                apply_reset();
            end
            repeat (rows[r].gap) begin
                @(posedge clk);
                hit <= 1'b0;
            end
            @(posedge clk);
            hit <= 1'b1;
            hit_code <= rows[r].code;
            if (r == n_rows - 1 || rows[r + 1].test != rows[r].test) begin
                finish_test(rows[r].test);
            end
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/hist_pkg.sv
verilog/hist_frame_counter.sv
verilog/hist_bin_ram.sv
verilog/hist_readout.sv
verilog/hist_builder_top.sv
dv/hist_builder_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module hist_builder_tb -f tb.f -o hist_sim \
    && ./obj_dir/hist_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
